/* compile.f */
hw/hyper_pkg.sv
hw/hyper_cfg_regs.sv
hw/hyper_cs_decode.sv
hw/hyper_ca_build.sv
hw/hyper_issue.sv
hw/hyper_frontend.sv
dv/tb_hyper_frontend.sv

/* dv/tb_hyper_frontend.sv */
// ================================================
// Random traffic against a register and CA model
// Config changes only while the pipeline is empty
// ================================================
`timescale 1ns/10ps
`default_nettype none

module tb_hyper_frontend;

    localparam int NR_CS     = 2;
    localparam int N_XFER    = 40;                  // Transfers per traffic phase
    localparam int N_RAND    = 16;                  // Random write/read pairs
    localparam int N_TX      = 3 * N_XFER + 2 * N_RAND + 60;
    localparam int WORST_CYC = 64;                  // Gap up to 15 plus stalls
    localparam logic [31:0] SPAN = 32'h0040_0000;   // Default 4 MiB window

    logic                   clk_i = 1'b0;
    logic                   arst_n_i;
    logic                   reg_req_i, reg_we_i, reg_ack_o, reg_err_o;
    hyper_pkg::hyper_word_t reg_addr_i, reg_wdata_i, reg_rdata_o;
    logic                   xfer_req_i, xfer_ack_o;
    hyper_pkg::hyper_xfer_t xfer_i;
    logic                   cmd_valid_o, cmd_ready_i, map_err_o;
    hyper_pkg::hyper_cmd_t  cmd_o;

    integer                 seed = 32'h73cb4eb7;
    int                     errors = 0;
    logic [7:0]             m_tlat, m_rwr;          // Register model
    logic                   m_en;
    logic [31:0]            m_map [2*NR_CS];
    hyper_pkg::hyper_cmd_t  exp_q [$];              // Expected commands, request order
    hyper_pkg::hyper_cmd_t  mon_exp;
    int                     miss_left = 0;
    int                     cyc = 0;
    int                     last_issue = 0;
    logic                   gap_armed = 1'b0;
    int                     reg_req_rise = 0, reg_ack_rise = 0;
    int                     xfer_req_rise = 0, xfer_ack_rise = 0;
    logic                   reg_req_q = 1'b0, reg_ack_q = 1'b0;
    logic                   xfer_req_q = 1'b0, xfer_ack_q = 1'b0;

    always #5 clk_i = ~clk_i;

    hyper_frontend #(.NR_CS(NR_CS)) DUT (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .reg_req_i(reg_req_i), .reg_we_i(reg_we_i), .reg_addr_i(reg_addr_i),
        .reg_wdata_i(reg_wdata_i), .reg_ack_o(reg_ack_o), .reg_rdata_o(reg_rdata_o),
        .reg_err_o(reg_err_o), .xfer_req_i(xfer_req_i), .xfer_i(xfer_i),
        .xfer_ack_o(xfer_ack_o), .cmd_valid_o(cmd_valid_o), .cmd_o(cmd_o),
        .cmd_ready_i(cmd_ready_i), .map_err_o(map_err_o)
    );

    initial begin
        #(N_TX * WORST_CYC * 10);
        $display("Watchdog expired, %0d commands still outstanding", exp_q.size());
        $display("test failed");
        $finish;
    end

    function automatic logic model_mapped(input logic [31:0] addr);
        if (addr[1:0] != 2'b00) return 1'b0;
        return (addr <= 32'h08) || (addr >= 32'h0C && addr < 32'h0C + 8 * NR_CS);
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        case (addr)
            32'h00:  return {24'h0, m_tlat};
            32'h04:  return {31'h0, m_en};          // Bit 0 only
            32'h08:  return {24'h0, m_rwr};
            default: return m_map[(addr - 32'h0C) >> 2];
        endcase
    endfunction

    // Four-phase master, one access per req phase
    task automatic reg_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk_i);
        reg_req_i   <= 1'b1;
        reg_we_i    <= we;
        reg_addr_i  <= addr;
        reg_wdata_i <= wdata;
        do @(posedge clk_i); while (!reg_ack_o);
        rdata = reg_rdata_o;                        // Valid while ack high
        err   = reg_err_o;
        reg_req_i <= 1'b0;
        do @(posedge clk_i); while (reg_ack_o);
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        reg_access(1'b1, addr, data, rdata, err);
        assert (err == !model_mapped(addr))
        else begin
            errors++;
            $display("FAIL reg_err_o write at %h got %h expected %h", addr, err, !model_mapped(addr));
        end
        if (model_mapped(addr)) begin
            case (addr)
                32'h00:  m_tlat = data[7:0];
                32'h04:  m_en   = data[0];
                32'h08:  m_rwr  = data[7:0];
                default: m_map[(addr - 32'h0C) >> 2] = data;
            endcase
        end
    endtask

    task automatic read_check(input logic [31:0] addr);
        logic [31:0] rdata;
        logic        err;
        reg_access(1'b0, addr, 32'h0, rdata, err);
        assert (err == !model_mapped(addr))
        else begin
            errors++;
            $display("FAIL reg_err_o read at %h got %h expected %h", addr, err, !model_mapped(addr));
        end
        if (model_mapped(addr)) begin
            assert (rdata == model_read(addr))
            else begin
                errors++;
                $display("FAIL reg_rdata_o at %h got %h expected %h", addr, rdata, model_read(addr));
            end
        end
    endtask

    task automatic set_window(input int cs, input logic [31:0] lo, input logic [31:0] hi);
        write_reg(32'h0C + 8 * cs, lo);
        write_reg(32'h10 + 8 * cs, hi);
    endtask

    task automatic check_all_regs();
        for (int a = 0; a < 12 + 8 * NR_CS; a += 4) read_check(a);
    endtask

    // Expected result from the decode, CA and latency rules
    task automatic send_xfer(input logic [31:0] addr, input logic rd);
        hyper_pkg::hyper_cmd_t exp;
        int                    cs;
        cs = -1;
        for (int i = 0; i < NR_CS; i++) begin
            if (cs < 0 && addr >= m_map[2*i] && addr <= m_map[2*i+1]) cs = i;   // Lowest wins
        end
        if (cs < 0) begin
            miss_left++;
        end else begin
            exp.cs  = 3'(cs);
            exp.ca  = {rd, 1'b0, 1'b1, addr[31:3], 13'h0, addr[2:0]};
            exp.lat = m_en ? 8'(m_tlat * 2) : m_tlat;
            exp_q.push_back(exp);
        end
        @(posedge clk_i);
        xfer_req_i <= 1'b1;
        xfer_i     <= '{addr: addr, rd: rd};
        do @(posedge clk_i); while (!xfer_ack_o);
        xfer_req_i <= 1'b0;
        do @(posedge clk_i); while (xfer_ack_o);
    endtask

    task automatic run_traffic(input logic [31:0] lo, input logic [31:0] span);
        logic [31:0] addr;
        logic        rd;
        gap_armed = 1'b0;                           // Gap left over from older t_rwr
        for (int n = 0; n < N_XFER; n++) begin
            addr = lo + ({$random(seed)} % span);
            rd   = $random(seed);
            send_xfer(addr, rd);
        end
        while (exp_q.size() != 0 || miss_left != 0) @(posedge clk_i);
        repeat (20) @(posedge clk_i);               // Catch stray commands
    endtask

    // Random back-pressure, ready high about 3 of 4 cycles
    always @(posedge clk_i) cmd_ready_i <= ({$random(seed)} % 4) != 0;

    // Issue port, error pulse and handshake monitor
    always @(posedge clk_i) begin
        if (arst_n_i) begin
            cyc++;
            if (cmd_valid_o && cmd_ready_i) begin
                assert (exp_q.size() != 0)
                else begin
                    errors++;
                    $display("Command issued while no transfer was outstanding");
                end
                if (exp_q.size() != 0) begin
                    mon_exp = exp_q.pop_front();
                    assert (cmd_o == mon_exp)
                    else begin
                        errors++;
                        $display("FAIL cmd_o got %h expected %h", cmd_o, mon_exp);
                    end
                end
                if (gap_armed) begin
                    assert (cyc - last_issue >= m_rwr)
                    else begin
                        errors++;
                        $display("FAIL cmd_valid_o gap got %h expected at least %h",
                                 cyc - last_issue, m_rwr);
                    end
                end
                last_issue = cyc;
                gap_armed  = 1'b1;
            end
            if (map_err_o) begin
                assert (miss_left > 0)
                else begin
                    errors++;
                    $display("map_err_o pulsed without an unmapped transfer");
                end
                if (miss_left > 0) miss_left--;
            end
            if (reg_ack_o && !reg_ack_q) begin
                reg_ack_rise++;
                assert (reg_req_q) else begin
                    errors++;
                    $display("reg_ack_o rose while reg_req_i was low");
                end
            end
            if (xfer_ack_o && !xfer_ack_q) begin
                xfer_ack_rise++;
                assert (xfer_req_q) else begin
                    errors++;
                    $display("xfer_ack_o rose while xfer_req_i was low");
                end
            end
            if (reg_req_i && !reg_req_q) reg_req_rise++;
            if (xfer_req_i && !xfer_req_q) xfer_req_rise++;
            reg_req_q  = reg_req_i;
            reg_ack_q  = reg_ack_o;
            xfer_req_q = xfer_req_i;
            xfer_ack_q = xfer_ack_o;
        end
    end

    initial begin
        logic [31:0] addr;
        arst_n_i    = 1'b0;
        reg_req_i   = 1'b0;
        reg_we_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        xfer_req_i  = 1'b0;
        xfer_i      = '0;
        cmd_ready_i = 1'b0;
        m_tlat      = 8'd6;
        m_en        = 1'b1;
        m_rwr       = 8'd6;
        for (int i = 0; i < NR_CS; i++) begin
            m_map[2*i]   = SPAN * i;
            m_map[2*i+1] = SPAN * (i + 1) - 1;
        end
        repeat (2) @(posedge clk_i);
        arst_n_i <= 1'b1;

        check_all_regs();                           // Reset values
        for (int n = 0; n < N_RAND; n++) begin
            addr = ({$random(seed)} % (12 + 8 * NR_CS)) & ~32'h3;
            write_reg(addr, $random(seed));
            read_check(addr);
        end
        write_reg(hyper_pkg::REG_EN_LAT_ADD, 32'hFFFF_FFFE);
        read_check(hyper_pkg::REG_EN_LAT_ADD);
        write_reg(32'h0C + 8 * NR_CS, 32'hDEAD_BEEF);   // Past the last window
        write_reg(32'h06, 32'h0000_00FF);               // Unaligned
        read_check(32'h100);
        read_check(32'h06);
        check_all_regs();                           // Bad offsets changed nothing

        // Default windows, additional latency on then off
        for (int i = 0; i < NR_CS; i++) set_window(i, SPAN * i, SPAN * (i + 1) - 1);
        write_reg(hyper_pkg::REG_T_LAT_ACCESS, {$random(seed)} % 16 + 1);
        write_reg(hyper_pkg::REG_EN_LAT_ADD, 32'h1);
        write_reg(hyper_pkg::REG_T_RWR, {$random(seed)} % 8 + 8);   // Longer than request spacing
        run_traffic(32'h0, SPAN * NR_CS);
        write_reg(hyper_pkg::REG_EN_LAT_ADD, 32'h0);
        write_reg(hyper_pkg::REG_T_RWR, {$random(seed)} % 16);
        run_traffic(32'h0, SPAN * NR_CS);

        // Overlapping ranges plus a hole above them
        set_window(0, 32'h1000, 32'h1FFF);
        set_window(1, 32'h0000, 32'h3FFF);
        write_reg(hyper_pkg::REG_EN_LAT_ADD, 32'h1);
        write_reg(hyper_pkg::REG_T_LAT_ACCESS, $random(seed));
        write_reg(hyper_pkg::REG_T_RWR, {$random(seed)} % 16);
        run_traffic(32'h0, 32'h6000);

        assert (reg_ack_rise == reg_req_rise) else begin
            errors++;
            $display("FAIL reg_ack_o rises got %h expected %h", reg_ack_rise, reg_req_rise);
        end
        assert (xfer_ack_rise == xfer_req_rise) else begin
            errors++;
            $display("FAIL xfer_ack_o rises got %h expected %h", xfer_ack_rise, xfer_req_rise);
        end
        $display("Done: %0d register phases, %0d transfer phases, %0d errors",
                 reg_req_rise, xfer_req_rise, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/hyper_frontend.sv */
// ================================================
// HyperBus request front end, no PHY and no data
// Request port acks once stage 1 is free
// ================================================
`timescale 1ns/10ps
`default_nettype none

module hyper_frontend #(
    parameter int NR_CS = 2                 // 1 to 8
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    // Register bus
    input  logic                   reg_req_i,
    input  logic                   reg_we_i,
    input  hyper_pkg::hyper_word_t reg_addr_i,
    input  hyper_pkg::hyper_word_t reg_wdata_i,
    output logic                   reg_ack_o,
    output hyper_pkg::hyper_word_t reg_rdata_o,
    output logic                   reg_err_o,
    // Request port
    input  logic                   xfer_req_i,
    input  hyper_pkg::hyper_xfer_t xfer_i,
    output logic                   xfer_ack_o,
    // Issue port
    output logic                   cmd_valid_o,
    output hyper_pkg::hyper_cmd_t  cmd_o,
    input  logic                   cmd_ready_i,
    output logic                   map_err_o
);

    typedef enum logic [1:0] {
        WAIT_REQ,
        ACK,
        WAIT_DROP
    } req_state_e;

    req_state_e state_q;

    hyper_pkg::hyper_timing_t             timing;
    hyper_pkg::hyper_word_t [2*NR_CS-1:0] addr_map;

    logic                  s1_valid;
    logic                  s1_ready;
    logic                  dec_valid;
    logic                  dec_ready;
    hyper_pkg::hyper_dec_t dec;
    logic                  ca_valid;
    logic                  ca_ready;
    hyper_pkg::hyper_cmd_t ca_cmd;

    // Four-phase slave; stage 1 is empty by the ACK cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= WAIT_REQ;
        end else begin
            case (state_q)
                WAIT_REQ:  if (xfer_req_i && s1_ready) state_q <= ACK;
                ACK:       state_q <= WAIT_DROP;   // Transfer handed over here
                WAIT_DROP: if (!xfer_req_i) state_q <= WAIT_REQ;
                default:   state_q <= WAIT_REQ;
            endcase
        end
    end

    assign s1_valid   = (state_q == ACK);      // Single valid per req phase
    assign xfer_ack_o = (state_q != WAIT_REQ);

    hyper_cfg_regs #(.NR_CS(NR_CS)) u_cfg_regs (
        .clk_i, .arst_n_i, .reg_req_i, .reg_we_i, .reg_addr_i, .reg_wdata_i,
        .reg_ack_o, .reg_rdata_o, .reg_err_o,
        .timing_o   (timing),
        .addr_map_o (addr_map)
    );

    hyper_cs_decode #(.NR_CS(NR_CS)) u_cs_decode (
        .clk_i, .arst_n_i,
        .in_valid_i (s1_valid),  .in_i (xfer_i), .addr_map_i (addr_map),
        .out_ready_i(dec_ready), .in_ready_o (s1_ready),
        .out_valid_o(dec_valid), .out_o (dec)
    );

    hyper_ca_build u_ca_build (
        .clk_i, .arst_n_i,
        .in_valid_i (dec_valid), .in_i (dec), .timing_i (timing),
        .out_ready_i(ca_ready),  .in_ready_o (dec_ready),
        .out_valid_o(ca_valid),  .out_o (ca_cmd), .map_err_o
    );

    hyper_issue u_issue (
        .clk_i, .arst_n_i,
        .in_valid_i (ca_valid), .in_i (ca_cmd), .timing_i (timing),
        .cmd_ready_i, .in_ready_o (ca_ready), .cmd_valid_o, .cmd_o
    );

    // Handover cycle must find stage 1 free
    a_s1_free : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        s1_valid |-> s1_ready);

endmodule

`default_nettype wire

/* hw/hyper_issue.sv */
// ================================================
// Stage 3: holds commands for the t_rwr gap
// t_rwr of 0 or 1 allows back-to-back issue
// ================================================
`timescale 1ns/10ps
`default_nettype none

module hyper_issue (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     in_valid_i,
    input  hyper_pkg::hyper_cmd_t    in_i,
    input  hyper_pkg::hyper_timing_t timing_i,
    input  logic                     cmd_ready_i,
    output logic                     in_ready_o,
    output logic                     cmd_valid_o,
    output hyper_pkg::hyper_cmd_t    cmd_o
);

    typedef enum logic {
        IDLE,
        RECOVER
    } issue_state_e;

    issue_state_e          state_q;
    hyper_pkg::hyper_lat_t cnt_q;          // Cycles left in the gap
    hyper_pkg::hyper_cmd_t cmd_q;
    logic                  full_q;
    logic                  issue;

    // Valid only once the gap has passed
    assign cmd_valid_o = full_q && (state_q == IDLE);
    assign issue       = cmd_valid_o && cmd_ready_i;
    assign in_ready_o  = !full_q || issue;

    // Recovery FSM
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (issue && timing_i.t_rwr > 8'd1) begin
                        state_q <= RECOVER;
                        cnt_q   <= timing_i.t_rwr - 8'd1;   // Issue cycle counts as one
                    end
                end
                RECOVER: begin
                    cnt_q <= cnt_q - 8'd1;
                    if (cnt_q <= 8'd1) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Command register occupancy
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full_q <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            full_q <= 1'b1;
        end else if (issue) begin
            full_q <= 1'b0;
        end
    end

    // Refill only when empty or being issued
    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            cmd_q <= in_i;
        end
    end

    assign cmd_o = cmd_q;

    a_cmd_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cmd_valid_o && !cmd_ready_i |=> cmd_valid_o && $stable(cmd_o));

endmodule

`default_nettype wire

/* hw/hyper_ca_build.sv */
// ================================================
// Stage 2: CA word and latency, linear memory burst
// Misses are dropped here and flagged on map_err_o
// ================================================
`timescale 1ns/10ps
`default_nettype none

module hyper_ca_build (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     in_valid_i,
    input  hyper_pkg::hyper_dec_t    in_i,
    input  hyper_pkg::hyper_timing_t timing_i,
    input  logic                     out_ready_i,
    output logic                     in_ready_o,
    output logic                     out_valid_o,
    output hyper_pkg::hyper_cmd_t    out_o,
    output logic                     map_err_o
);

    hyper_pkg::hyper_cmd_t cmd_d;
    hyper_pkg::hyper_cmd_t out_q;
    logic                  out_valid_q;
    logic                  map_err_q;
    logic                  take;

    always_comb begin
        cmd_d.cs = in_i.cs;
        cmd_d.ca = {in_i.xfer.rd,           // 47 read
                    1'b0,                   // 46 memory space
                    1'b1,                   // 45 linear burst
                    in_i.xfer.addr[31:3],   // Upper address
                    13'b0,                  // Reserved
                    in_i.xfer.addr[2:0]};   // Lower address
        // Fixed double latency when additional latency is on
        cmd_d.lat = timing_i.en_lat_add ? {timing_i.t_lat_access[6:0], 1'b0}
                                        : timing_i.t_lat_access;
    end

    assign in_ready_o = !out_valid_q || out_ready_i;
    assign take       = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_q <= 1'b0;
            map_err_q   <= 1'b0;
        end else begin
            map_err_q <= take && !in_i.hit;    // One-cycle pulse per miss
            if (take) begin
                out_valid_q <= in_i.hit;        // Miss leaves nothing behind
            end else if (out_ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take && in_i.hit) begin
            out_q <= cmd_d;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_o       = out_q;
    assign map_err_o   = map_err_q;

endmodule

`default_nettype wire

/* hw/hyper_cs_decode.sv */
// ================================================
// Stage 1: address to chip select, lowest CS wins
// Ranges are inclusive; misses pass with hit low
// ================================================
`timescale 1ns/10ps
`default_nettype none

module hyper_cs_decode #(
    parameter int NR_CS = 2
) (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,
    input  logic                                 in_valid_i,
    input  hyper_pkg::hyper_xfer_t               in_i,
    input  hyper_pkg::hyper_word_t [2*NR_CS-1:0] addr_map_i,
    input  logic                                 out_ready_i,
    output logic                                 in_ready_o,
    output logic                                 out_valid_o,
    output hyper_pkg::hyper_dec_t                out_o
);

    hyper_pkg::hyper_dec_t dec_d;
    hyper_pkg::hyper_dec_t out_q;
    logic                  out_valid_q;

    // All ranges in parallel; walk downward so CS0 has priority
    always_comb begin
        dec_d.xfer = in_i;
        dec_d.hit  = 1'b0;
        dec_d.cs   = '0;
        for (int i = NR_CS - 1; i >= 0; i--) begin
            if (in_i.addr >= addr_map_i[2*i] && in_i.addr <= addr_map_i[2*i+1]) begin
                dec_d.hit = 1'b1;
                dec_d.cs  = hyper_pkg::hyper_cs_idx_t'(i);
            end
        end
    end

    // Empty or draining this cycle
    assign in_ready_o = !out_valid_q || out_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    // Payload, no reset
    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            out_q <= dec_d;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_o       = out_q;

    // Held result stays put under stall
    a_hold_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o));

endmodule

`default_nettype wire

/* hw/hyper_cfg_regs.sv */
// ================================================
// Config registers on a four-phase register bus
// Timing regs keep 8 bits, en_lat_add keeps bit 0
// Bad or unaligned offset acks with err, no write
// ================================================
`timescale 1ns/10ps
`default_nettype none

module hyper_cfg_regs #(
    parameter int NR_CS = 2
) (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                reg_req_i,
    input  logic                                reg_we_i,
    input  hyper_pkg::hyper_word_t              reg_addr_i,
    input  hyper_pkg::hyper_word_t              reg_wdata_i,
    output logic                                reg_ack_o,
    output hyper_pkg::hyper_word_t              reg_rdata_o,
    output logic                                reg_err_o,
    output hyper_pkg::hyper_timing_t            timing_o,
    output hyper_pkg::hyper_word_t [2*NR_CS-1:0] addr_map_o  // Even start, odd end
);

    hyper_pkg::hyper_lat_t               t_lat_q;
    hyper_pkg::hyper_lat_t               t_rwr_q;
    logic                                en_lat_add_q;
    hyper_pkg::hyper_word_t [2*NR_CS-1:0] map_q;

    logic                   ack_q;
    logic                   err_q;
    hyper_pkg::hyper_word_t rdata_q;

    // Offset decode
    logic                   aligned;
    logic                   map_sel;
    logic                   valid_off;
    hyper_pkg::hyper_word_t map_off;
    logic [3:0]             map_idx;
    hyper_pkg::hyper_word_t rd_val;
    logic                   access;                 // Ack rises this cycle

    assign aligned = (reg_addr_i[1:0] == 2'b00);
    assign map_off = reg_addr_i - hyper_pkg::REG_ADDR_MAP_BASE;
    assign map_idx = map_off[5:2];
    assign map_sel = aligned && (reg_addr_i >= hyper_pkg::REG_ADDR_MAP_BASE)
                     && (map_off < 32'(8 * NR_CS));
    assign access  = reg_req_i && !ack_q;

    always_comb begin
        rd_val    = '0;
        valid_off = aligned;
        if (reg_addr_i == hyper_pkg::REG_T_LAT_ACCESS) begin
            rd_val = {24'b0, t_lat_q};
        end else if (reg_addr_i == hyper_pkg::REG_EN_LAT_ADD) begin
            rd_val = {31'b0, en_lat_add_q};         // Masked to bit 0
        end else if (reg_addr_i == hyper_pkg::REG_T_RWR) begin
            rd_val = {24'b0, t_rwr_q};
        end else if (map_sel) begin
            rd_val = map_q[map_idx];
        end else begin
            valid_off = 1'b0;
        end
    end

    // Handshake and readback
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
            rdata_q <= '0;
        end else if (access) begin
            ack_q   <= 1'b1;
            err_q   <= !valid_off;
            rdata_q <= reg_we_i ? '0 : rd_val;     // Data only on reads
        end else if (!reg_req_i) begin
            ack_q <= 1'b0;                          // Drop one cycle after req
        end
    end

    // Register storage, written as ack rises
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            t_lat_q      <= hyper_pkg::RST_T_LAT_ACCESS;
            en_lat_add_q <= hyper_pkg::RST_EN_LAT_ADD;
            t_rwr_q      <= hyper_pkg::RST_T_RWR;
            for (int i = 0; i < NR_CS; i++) begin
                // Default i-th 4 MiB window
                map_q[2*i]   <= hyper_pkg::RST_CS_SPAN * hyper_pkg::hyper_word_t'(i);
                map_q[2*i+1] <= hyper_pkg::RST_CS_SPAN * hyper_pkg::hyper_word_t'(i + 1) - 1;
            end
        end else if (access && reg_we_i && valid_off) begin
            if (reg_addr_i == hyper_pkg::REG_T_LAT_ACCESS) t_lat_q <= reg_wdata_i[7:0];
            else if (reg_addr_i == hyper_pkg::REG_EN_LAT_ADD) en_lat_add_q <= reg_wdata_i[0];
            else if (reg_addr_i == hyper_pkg::REG_T_RWR) t_rwr_q <= reg_wdata_i[7:0];
            else map_q[map_idx] <= reg_wdata_i;
        end
    end

    assign reg_ack_o   = ack_q;
    assign reg_rdata_o = rdata_q;
    assign reg_err_o   = err_q;
    assign addr_map_o  = map_q;
    assign timing_o    = '{t_lat_access: t_lat_q, en_lat_add: en_lat_add_q, t_rwr: t_rwr_q};

    // Four-phase slave never acks unasked
    a_ack_needs_req : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(reg_ack_o) |-> $past(reg_req_i));

    a_nr_cs_range : assert property (@(posedge clk_i)
        NR_CS >= 1 && NR_CS <= hyper_pkg::MAX_CS);

endmodule

`default_nettype wire

/* hw/hyper_pkg.sv */
// ================================================
// Shared widths, payload structs and register map
// Up to MAX_CS chip selects, word aligned offsets
// ================================================
`default_nettype none

package hyper_pkg;

    // Plain vectors with a meaning
    typedef logic [31:0] hyper_word_t;      // Register or address word
    typedef logic [2:0]  hyper_cs_idx_t;    // Chip select index
    typedef logic [7:0]  hyper_lat_t;       // Cycle count
    typedef logic [47:0] hyper_ca_t;        // HyperBus command-address

    localparam int MAX_CS = 8;

    // Transfer request from the request port
    typedef struct packed {
        hyper_word_t addr;
        logic        rd;                    // Set for read
    } hyper_xfer_t;

    // Stage 1 result
    typedef struct packed {
        hyper_xfer_t   xfer;
        hyper_cs_idx_t cs;
        logic          hit;                 // Cleared on unmapped address
    } hyper_dec_t;

    // Issued command
    typedef struct packed {
        hyper_cs_idx_t cs;
        hyper_ca_t     ca;
        hyper_lat_t    lat;
    } hyper_cmd_t;

    // Timing config seen by the stages
    typedef struct packed {
        hyper_lat_t t_lat_access;
        logic       en_lat_add;
        hyper_lat_t t_rwr;
    } hyper_timing_t;

    // Byte offsets on the register bus
    localparam hyper_word_t REG_T_LAT_ACCESS  = 32'h00;
    localparam hyper_word_t REG_EN_LAT_ADD    = 32'h04;
    localparam hyper_word_t REG_T_RWR         = 32'h08;
    localparam hyper_word_t REG_ADDR_MAP_BASE = 32'h0C;   // Start at +8i, end at +8i+4

    // Reset values
    localparam hyper_lat_t  RST_T_LAT_ACCESS = 8'd6;
    localparam logic        RST_EN_LAT_ADD   = 1'b1;
    localparam hyper_lat_t  RST_T_RWR        = 8'd6;
    localparam hyper_word_t RST_CS_SPAN      = 32'h0040_0000;  // 4 MiB per chip select

endpackage

`default_nettype wire
